/* list.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache_data_ram.sv
logic/icache_lookup.sv
logic/icache_refill.sv
logic/icache_top.sv
tests/tb_clock.sv
tests/axi_slave_mem.sv
tests/icache_tb.sv

/* logic/icache_data_ram.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_ram
    import icache_pkg::*;
(
    input  logic                      aclk,
    input  ram_wr_t                   wr,
    input  logic [`ICACHE_RAM_AW-1:0] raddr,
    output logic [31:0]               rdata
);

    localparam int DEPTH = `ICACHE_LINES * `ICACHE_LINE_WORDS;

    // One word per entry, index and offset form the address.
    logic [31:0] mem [DEPTH];

    always_ff @(posedge aclk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read is combinational so a hit returns data in the fetch cycle.
    assign rdata = mem[raddr];

endmodule

/* logic/icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Cache geometry.
`define ICACHE_LINES        64
`define ICACHE_LINE_WORDS   16

// Fetch address fields.
`define ICACHE_OFS_LO       2
`define ICACHE_OFS_HI       5
`define ICACHE_IDX_LO       6
`define ICACHE_IDX_HI       11
`define ICACHE_TAG_LO       12

// Derived widths.
`define ICACHE_TAG_W        (32 - `ICACHE_TAG_LO)
`define ICACHE_RAM_AW       (`ICACHE_IDX_HI - `ICACHE_OFS_LO + 1)
`define ICACHE_IDX_W        (`ICACHE_IDX_HI - `ICACHE_IDX_LO + 1)

// AXI read IDs.
`define ICACHE_ID_CACHED    4'd3
`define ICACHE_ID_UNCACHED  4'd2

`endif

/* logic/icache_lookup.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic                      aclk,
    input  logic                      aresetn,
    input  fetch_req_t                fetch,
    input  logic                      busy,
    input  line_fill_t                line_fill,
    input  uc_fill_t                  uc_fill,
    input  logic                      uc_clear,
    output logic                      streq,
    output miss_t                     miss,
    output logic [`ICACHE_RAM_AW-1:0] ram_raddr,
    output logic [31:0]               uc_data
);

    logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] line_valid;

    logic [31:0] uc_addr;
    logic        uc_valid;

    logic [`ICACHE_IDX_W-1:0] fetch_idx;
    logic [`ICACHE_TAG_W-1:0] fetch_tag;
    logic                     line_hit;
    logic                     uc_hit;
    logic                     hit;
    logic                     cached_miss;

    assign fetch_idx = fetch.addr[`ICACHE_IDX_HI:`ICACHE_IDX_LO];
    assign fetch_tag = fetch.addr[31:`ICACHE_TAG_LO];

    assign line_hit = line_valid[fetch_idx] && (tag_mem[fetch_idx] == fetch_tag);
    assign uc_hit   = uc_valid && (uc_addr == fetch.addr);
    assign hit      = fetch.cached ? line_hit : uc_hit;

    assign streq = fetch.en && !hit;

    // Only one miss in flight, so hold off while refill is busy.
    assign miss = '{
        valid:  streq && !busy,
        addr:   fetch.cached ? {fetch.addr[31:`ICACHE_IDX_LO], {`ICACHE_IDX_LO{1'b0}}}
                             : fetch.addr,
        cached: fetch.cached
    };

    assign cached_miss = miss.valid && miss.cached;

    assign ram_raddr = fetch.addr[`ICACHE_IDX_HI:`ICACHE_OFS_LO];

    // Tag is written up front; valid follows when the fill completes.
    always_ff @(posedge aclk) begin
        if (cached_miss) begin
            tag_mem[fetch_idx] <= fetch_tag;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            line_valid <= '0;
        end else begin
            if (cached_miss) begin
                line_valid[fetch_idx] <= 1'b0;
            end
            if (line_fill.valid) begin
                line_valid[line_fill.idx] <= 1'b1;
            end
        end
    end

    // One entry buffer for uncached fetches.
    always_ff @(posedge aclk) begin
        if (uc_fill.valid) begin
            uc_addr <= uc_fill.addr;
            uc_data <= uc_fill.data;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            uc_valid <= 1'b0;
        end else if (uc_fill.valid) begin
            uc_valid <= 1'b1;
        end else if (uc_clear) begin
            uc_valid <= 1'b0;
        end
    end

endmodule

/* logic/icache_pkg.sv */
`include "icache_defines.svh"

package icache_pkg;

    // Processor fetch request.
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
        logic        cached;
    } fetch_req_t;

    // Miss strobe, line aligned when cached.
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic        cached;
    } miss_t;

    // AXI read address fields.
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [3:0]  len;
    } ar_req_t;

    // AXI read data beat.
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } r_beat_t;

    typedef struct packed {
        logic                      en;
        logic [`ICACHE_RAM_AW-1:0] addr;
        logic [31:0]               data;
    } ram_wr_t;

    // Line fill finished.
    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_IDX_W-1:0] idx;
    } line_fill_t;

    // Uncached word arrived.
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } uc_fill_t;

endpackage

/* logic/icache_refill.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_refill
    import icache_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  miss_t      miss,
    input  logic       stall,
    input  logic       streq,
    input  logic       arready,
    input  r_beat_t    r,
    input  logic       rvalid,
    output ar_req_t    ar,
    output logic       arvalid,
    output logic       busy,
    output ram_wr_t    ram_wr,
    output line_fill_t line_fill,
    output uc_fill_t   uc_fill,
    output logic       uc_clear
);

    localparam int BEAT_W = $clog2(`ICACHE_LINE_WORDS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_DONE
    } state_t;

    state_t                    state;
    miss_t                     miss_q;
    logic [BEAT_W-1:0]         beat_cnt;
    logic [`ICACHE_IDX_W-1:0]  line_idx;

    logic                      wr_en;
    logic [`ICACHE_RAM_AW-1:0] wr_addr;
    logic [31:0]               wr_data;

    logic                      beat;
    logic                      done_ack;

    assign line_idx = miss_q.addr[`ICACHE_IDX_HI:`ICACHE_IDX_LO];
    assign beat     = (state == S_DATA) && rvalid;

    // Processor has seen the current streq level.
    assign done_ack = (state == S_DONE) && (stall == streq);

    assign busy = (state != S_IDLE);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= S_IDLE;
            arvalid  <= 1'b0;
            beat_cnt <= '0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (miss.valid) begin
                        state    <= S_ADDR;
                        arvalid  <= 1'b1;
                        beat_cnt <= '0;
                    end
                end
                S_ADDR: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (rvalid) begin
                        if (miss_q.cached) begin
                            wr_en    <= 1'b1;
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                        if (r.last) begin
                            state <= S_DONE;
                        end
                    end
                end
                S_DONE: begin
                    if (done_ack) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == S_IDLE && miss.valid) begin
            miss_q <= miss;
        end
        if (beat) begin
            wr_addr <= {line_idx, beat_cnt};
            wr_data <= r.data;
        end
    end

    // Address fields come straight from the latched miss.
    assign ar = '{
        id:   miss_q.cached ? `ICACHE_ID_CACHED : `ICACHE_ID_UNCACHED,
        addr: miss_q.addr,
        len:  miss_q.cached ? 4'(`ICACHE_LINE_WORDS - 1) : 4'd0
    };

    assign ram_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

    assign line_fill = '{
        valid: (state == S_DONE) && miss_q.cached,
        idx:   line_idx
    };

    // Buffer turns valid with the single beat.
    assign uc_fill = '{
        valid: beat && r.last && !miss_q.cached,
        addr:  miss_q.addr,
        data:  r.data
    };

    assign uc_clear = done_ack;

endmodule

/* logic/icache_top.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    // Fetch port.
    input  fetch_req_t fetch,
    input  logic       stall,
    output logic [31:0] rdata,
    output logic       streq,

    // AXI read channel.
    output ar_req_t    ar,
    output logic       arvalid,
    input  logic       arready,
    input  r_beat_t    r,
    input  logic       rvalid
);

    miss_t                     miss;
    logic                      busy;
    line_fill_t                line_fill;
    uc_fill_t                  uc_fill;
    logic                      uc_clear;
    logic [31:0]               uc_data;

    ram_wr_t                   ram_wr;
    logic [`ICACHE_RAM_AW-1:0] ram_raddr;
    logic [31:0]               ram_rdata;

    icache_lookup u_lookup (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .fetch     (fetch),
        .busy      (busy),
        .line_fill (line_fill),
        .uc_fill   (uc_fill),
        .uc_clear  (uc_clear),
        .streq     (streq),
        .miss      (miss),
        .ram_raddr (ram_raddr),
        .uc_data   (uc_data)
    );

    icache_refill u_refill (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .miss      (miss),
        .stall     (stall),
        .streq     (streq),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .ar        (ar),
        .arvalid   (arvalid),
        .busy      (busy),
        .ram_wr    (ram_wr),
        .line_fill (line_fill),
        .uc_fill   (uc_fill),
        .uc_clear  (uc_clear)
    );

    icache_data_ram u_data_ram (
        .aclk  (aclk),
        .wr    (ram_wr),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    // Uncached fetches read from the one word buffer.
    assign rdata = fetch.cached ? ram_rdata : uc_data;

endmodule

/* tests/axi_slave_mem.sv */
`timescale 1ns/1ps

module axi_slave_mem
    import icache_pkg::*;
#(
    parameter int SEED = 36560
) (
    input  logic    aclk,
    input  logic    aresetn,
    input  ar_req_t ar,
    input  logic    arvalid,
    output logic    arready,
    output r_beat_t r,
    output logic    rvalid
);

    integer      seed;
    logic [1:0]  phase;
    logic [2:0]  delay;
    logic [31:0] base;
    logic [3:0]  len_q;
    logic [3:0]  taken;

    initial seed = SEED;

    // Memory contents follow a fixed rule on the word address.
    function automatic logic [31:0] word_at(input logic [31:0] byte_addr);
        return {2'b00, byte_addr[31:2]} * 32'h9E3779B1 + 32'h1234;
    endfunction

    // Phases: wait for address, arready delay, handshake, data beats.
    always @(posedge aclk or negedge aresetn) begin : slave_fsm
        logic [3:0]  next_taken;
        logic [31:0] rnd;
        if (!aresetn) begin
            phase   <= 2'd0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            r       <= '0;
            delay   <= '0;
            taken   <= '0;
        end else begin
            rnd = $random(seed);
            case (phase)
                2'd0: begin
                    if (arvalid) begin
                        delay <= rnd[2:0];
                        phase <= 2'd1;
                    end
                end
                2'd1: begin
                    if (delay == 3'd0) begin
                        arready <= 1'b1;
                        phase   <= 2'd2;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                2'd2: begin
                    if (arvalid && arready) begin
                        arready <= 1'b0;
                        base    <= ar.addr;
                        len_q   <= ar.len;
                        taken   <= '0;
                        phase   <= 2'd3;
                    end
                end
                default: begin
                    if (rvalid && r.last) begin
                        rvalid <= 1'b0;
                        phase  <= 2'd0;
                    end else begin
                        // Random gaps between beats, about one in four.
                        next_taken = rvalid ? taken + 1'b1 : taken;
                        taken  <= next_taken;
                        rvalid <= (rnd[4:3] != 2'b00);
                        r      <= '{data: word_at(base + {next_taken, 2'b00}),
                                    last: (next_taken == len_q)};
                    end
                end
            endcase
        end
    end

endmodule

/* tests/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int NUM_FETCHES    = 500;
    localparam int TIMEOUT_CYCLES = NUM_FETCHES * 48;

    logic        aclk;
    logic        aresetn;
    fetch_req_t  fetch;
    logic        stall;
    logic [31:0] rdata;
    logic        streq;
    ar_req_t     ar;
    logic        arvalid;
    logic        arready;
    r_beat_t     r;
    logic        rvalid;

    integer      seed;
    int          cycle_count = 0;
    int          ar_count;
    logic        streq_prev;
    logic        hold_pending;
    ar_req_t     last_ar;
    ar_req_t     ar_hold;
    logic [19:0] model_tag [64];
    logic [63:0] model_valid;
    logic [31:0] last_uc_addr;
    logic        have_uc_addr;

    tb_clock u_clock (.aclk(aclk));

    icache_top DUT (
        .aclk    (aclk),
        .aresetn (aresetn),
        .fetch   (fetch),
        .stall   (stall),
        .rdata   (rdata),
        .streq   (streq),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid)
    );

    axi_slave_mem u_slave (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid)
    );

    function automatic logic [31:0] expected_word(input logic [31:0] byte_addr);
        return {2'b00, byte_addr[31:2]} * 32'h9E3779B1 + 32'h1234;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "check failed: %s", name);
        end
    endtask

    // Drive on the falling edge and sample while the clock is low.
    task automatic run_cycle(input logic en, input logic [31:0] addr, input logic cached);
        @(negedge aclk);
        stall = streq_prev;
        fetch = '{en: en, addr: addr, cached: cached};
        #2;
        streq_prev = streq;
        if (arvalid) begin
            if (hold_pending) begin
                check_value("ar stable while waiting", ar_hold, ar);
            end
            ar_hold      = ar;
            hold_pending = !arready;
            if (arready) begin
                ar_count++;
                last_ar = ar;
            end
        end else begin
            check_value("arvalid held until handshake", 1'b0, hold_pending);
        end
    endtask

    task automatic run_idle();
        run_cycle(1'b0, '0, 1'b0);
        check_value("streq with en low", 1'b0, streq);
        check_value("arvalid when idle", 1'b0, arvalid);
    endtask

    task automatic pick_request(output logic [31:0] addr, output logic cached);
        logic [31:0] rnd;
        rnd    = $random(seed);
        cached = (rnd[2:0] != 3'd0);
        if (cached) begin
            // Four tags over eight lines.
            addr = {20'h00010 + rnd[4:3], 3'b000, rnd[7:5], rnd[11:8], 2'b00};
        end else if (rnd[3] && have_uc_addr) begin
            addr = last_uc_addr;
        end else begin
            addr         = {20'h00080 + rnd[5:4], rnd[17:8], 2'b00};
            last_uc_addr = addr;
            have_uc_addr = 1'b1;
        end
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic cached);
        logic [5:0]  idx;
        logic [19:0] tag;
        logic        exp_hit;
        idx      = addr[11:6];
        tag      = addr[31:12];
        exp_hit  = cached && model_valid[idx] && (model_tag[idx] == tag);
        ar_count = 0;
        run_cycle(1'b1, addr, cached);
        check_value(cached ? "cached streq" : "uncached streq", !exp_hit, streq);
        while (streq) begin
            run_cycle(1'b1, addr, cached);
        end
        check_value("rdata", expected_word(addr), rdata);
        check_value("address count", exp_hit ? 0 : 1, ar_count);
        if (!exp_hit) begin
            check_value("ar id", cached ? 3 : 2, last_ar.id);
            check_value("ar len", cached ? 15 : 0, last_ar.len);
            check_value("ar addr", cached ? {addr[31:6], 6'd0} : addr, last_ar.addr);
        end
        if (cached) begin
            model_tag[idx]   = tag;
            model_valid[idx] = 1'b1;
        end else begin
            // Refill returns to idle and drops the buffer here.
            run_idle();
        end
    endtask

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d clock cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] addr;
        logic        cached;
        logic [31:0] rnd;
        seed         = 36560;
        ar_count     = 0;
        aresetn      = 1'b0;
        fetch        = '0;
        stall        = 1'b0;
        streq_prev   = 1'b0;
        hold_pending = 1'b0;
        last_ar      = '0;
        ar_hold      = '0;
        model_valid  = '0;
        last_uc_addr = '0;
        have_uc_addr = 1'b0;
        repeat (10) run_idle();
        @(negedge aclk);
        aresetn = 1'b1;
        repeat (4) run_idle();
        for (int i = 0; i < NUM_FETCHES; i++) begin
            rnd = $random(seed);
            if (rnd[2:0] == 3'd0) begin
                run_idle();
            end
            pick_request(addr, cached);
            run_fetch(addr, cached);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD = 8.0
) (
    output logic aclk
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2.0) aclk = ~aclk;
    end

endmodule
